// File: src/rv_isa_pkg.sv
// RV32 encodings for the I, M and Zicsr subset only; no float, atomic, RV64 or S-mode codes.
package rv_isa_pkg;

    parameter int XLEN      = 32;
    parameter int REG_IDX_W = 5;

    // Bit positions of the fixed instruction fields.
    parameter int RD_LSB     = 7;
    parameter int FUNCT3_LSB = 12;
    parameter int RS1_LSB    = 15;
    parameter int RS2_LSB    = 20;
    parameter int FUNCT7_LSB = 25;

    parameter logic [31:0] MRET_WORD = 32'h3020_0073;

    // Major opcodes, instruction bits 6 to 2.
    typedef enum logic [4:0] {
        LOAD     = 5'b00000,
        MISC_MEM = 5'b00011,
        OP_IMM   = 5'b00100,
        AUIPC    = 5'b00101,
        STORE    = 5'b01000,
        OP       = 5'b01100,
        LUI      = 5'b01101,
        BRANCH   = 5'b11000,
        JALR     = 5'b11001,
        JAL      = 5'b11011,
        SYSTEM   = 5'b11100
    } opcode_e;

    typedef enum logic [2:0] {
        ADD  = 3'b000,
        SLL  = 3'b001,
        SLT  = 3'b010,
        SLTU = 3'b011,
        XOR  = 3'b100,
        SRL  = 3'b101,
        OR   = 3'b110,
        AND  = 3'b111
    } funct3_alu_e;

    typedef enum logic [1:0] {
        PRIV_U = 2'd0,
        PRIV_M = 2'd3
    } priv_e;

    // Exception causes as in mcause.
    typedef enum logic [3:0] {
        INSN_MISALIGNED   = 4'd0,
        INSN_ACCESS_FAULT = 4'd1,
        ILLEGAL_INSN      = 4'd2,
        BREAKPOINT        = 4'd3,
        ECALL_U           = 4'd8,
        ECALL_M           = 4'd11,
        INSN_PAGE_FAULT   = 4'd12
    } cause_e;

endpackage

// File: src/boa_pipe_pkg.sv
// Inter-stage buses of the pipeline; the PC is halfword aligned, so bit 0 is not carried.
package boa_pipe_pkg;

    // Fetch to decode.
    typedef struct packed {
        logic                          valid;
        logic [rv_isa_pkg::XLEN-1:1]   pc;
        logic [31:0]                   insn;
        logic                          trap;
        rv_isa_pkg::cause_e            cause;
    } if_id_t;

    // Register write-back.
    typedef struct packed {
        logic                              we;
        logic [rv_isa_pkg::REG_IDX_W-1:0]  rd;
        logic [rv_isa_pkg::XLEN-1:0]       wdata;
    } wb_t;

    // Decode to execute.
    typedef struct packed {
        logic                          valid;
        logic [rv_isa_pkg::XLEN-1:1]   pc;
        logic [31:0]                   insn;
        logic                          use_rd;
        logic [rv_isa_pkg::XLEN-1:0]   rs1_val;
        logic [rv_isa_pkg::XLEN-1:0]   rs2_val;
        logic                          branch;
        logic                          branch_predict;
        logic                          trap;
        rv_isa_pkg::cause_e            cause;
    } id_ex_t;

    // Control flow information back to fetch.
    typedef struct packed {
        logic                          is_xret;
        logic                          is_jump;
        logic                          is_branch;
        logic                          branch_predict;
        logic [rv_isa_pkg::XLEN-1:1]   branch_target;
    } flow_t;

endpackage

// File: src/boa_regfile.sv
// Read-first register file: a write-back shows up on the read ports one cycle after its edge.
`timescale 1ns/1ps

module boa_regfile (
    input  logic                              clk,
    input  logic                              rst,
    input  boa_pipe_pkg::wb_t                 wb,
    input  logic [rv_isa_pkg::REG_IDX_W-1:0]  rs1,
    input  logic [rv_isa_pkg::REG_IDX_W-1:0]  rs2,
    output logic [rv_isa_pkg::XLEN-1:0]       rs1_val,
    output logic [rv_isa_pkg::XLEN-1:0]       rs2_val
);

    // x0 has no storage.
    logic [rv_isa_pkg::XLEN-1:0] regs [1:31];

    // Combinational reads return the value stored before this edge.
    assign rs1_val = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_val = (rs2 == '0) ? '0 : regs[rs2];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.we && (wb.rd != '0)) begin
            regs[wb.rd] <= wb.wdata;
        end
    end

endmodule

// File: src/boa_insn_validator.sv
// Checks RV32I plus optional M and Zicsr encodings; privilege only restricts MRET to M mode.
`timescale 1ns/1ps

module boa_insn_validator #(
    parameter bit have_m     = 1'b1,
    parameter bit have_zicsr = 1'b1
) (
    input  logic [31:0]        insn,
    input  rv_isa_pkg::priv_e  privilege,
    output logic               valid,
    output logic               legal
);

    rv_isa_pkg::funct3_alu_e funct3;
    logic [6:0]              funct7;
    logic                    valid_op_imm;
    logic                    valid_op;
    logic                    valid_system;
    logic                    legal_system;

    assign funct3 = rv_isa_pkg::funct3_alu_e'(insn[rv_isa_pkg::FUNCT3_LSB +: 3]);
    assign funct7 = insn[rv_isa_pkg::FUNCT7_LSB +: 7];

    // Shift immediates only allow the SRAI bit above the shift amount.
    always_comb begin
        case (funct3)
            rv_isa_pkg::SLL: valid_op_imm = (funct7 == 7'b0000000);
            rv_isa_pkg::SRL: valid_op_imm = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
            default:         valid_op_imm = 1'b1;
        endcase
    end

    // Register-register ALU and multiply/divide.
    always_comb begin
        case (funct7)
            7'b0000000: valid_op = 1'b1;
            7'b0100000: valid_op = (funct3 == rv_isa_pkg::ADD) || (funct3 == rv_isa_pkg::SRL);
            7'b0000001: valid_op = have_m;
            default:    valid_op = 1'b0;
        endcase
    end

    always_comb begin
        valid_system = 1'b0;
        legal_system = 1'b1;
        if (insn[14:12] == 3'b000) begin
            // ECALL, EBREAK and WFI have all register fields zero.
            if (insn == rv_isa_pkg::MRET_WORD) begin
                valid_system = 1'b1;
                legal_system = (privilege == rv_isa_pkg::PRIV_M);
            end else if (insn[19:7] == '0) begin
                valid_system = (insn[31:21] == '0) || (insn[31:20] == 12'h105);
            end
        end else begin
            // CSR access; funct3 100 is unused.
            valid_system = have_zicsr && (insn[14:12] != 3'b100);
        end
    end

    always_comb begin
        legal = 1'b1;
        valid = 1'b0;
        if (insn[1:0] == 2'b11) begin
            case (rv_isa_pkg::opcode_e'(insn[6:2]))
                rv_isa_pkg::LOAD:     valid = insn[14] ? (insn[13:12] < 2'd2)
                                                       : (insn[13:12] < 2'd3);
                rv_isa_pkg::STORE:    valid = !insn[14] && (insn[13:12] != 2'd3);
                rv_isa_pkg::MISC_MEM: valid = (insn[14:12] == 3'b000);
                rv_isa_pkg::OP_IMM:   valid = valid_op_imm;
                rv_isa_pkg::OP:       valid = valid_op;
                rv_isa_pkg::BRANCH:   valid = insn[14] || !insn[13];
                rv_isa_pkg::JALR:     valid = (insn[14:12] == 3'b000);
                rv_isa_pkg::LUI,
                rv_isa_pkg::AUIPC,
                rv_isa_pkg::JAL:      valid = 1'b1;
                rv_isa_pkg::SYSTEM: begin
                    valid = valid_system;
                    legal = legal_system;
                end
                default:              valid = 1'b0;
            endcase
        end
    end

endmodule

// File: src/boa_reg_decoder.sv
// Reports destination register use only; source register use is left to the hazard logic.
`timescale 1ns/1ps

module boa_reg_decoder (
    input  logic [31:0] insn,
    output logic        use_rd
);

    logic [2:0] funct3;

    assign funct3 = insn[rv_isa_pkg::FUNCT3_LSB +: 3];

    always_comb begin
        case (rv_isa_pkg::opcode_e'(insn[6:2]))
            rv_isa_pkg::LOAD,
            rv_isa_pkg::OP_IMM,
            rv_isa_pkg::JALR,
            rv_isa_pkg::OP,
            rv_isa_pkg::LUI,
            rv_isa_pkg::AUIPC,
            rv_isa_pkg::JAL:    use_rd = 1'b1;
            // CSR forms write rd, privileged forms do not.
            rv_isa_pkg::SYSTEM: use_rd = (funct3 != 3'b000);
            // Stores, branches and fences.
            default:            use_rd = 1'b0;
        endcase
    end

endmodule

// File: src/boa_branch_decoder.sv
// Static prediction on the sign bit; a JALR target uses rs1 straight from the register file.
`timescale 1ns/1ps

module boa_branch_decoder (
    input  logic [31:0]                   insn,
    input  logic [rv_isa_pkg::XLEN-1:1]   pc,
    input  logic [rv_isa_pkg::XLEN-1:0]   rs1_val,
    output boa_pipe_pkg::flow_t           flow
);

    logic [rv_isa_pkg::XLEN-1:0] add_lhs;
    logic [rv_isa_pkg::XLEN-1:0] add_rhs;
    logic [rv_isa_pkg::XLEN-1:0] add_res;

    assign add_res = add_lhs + add_rhs;

    always_comb begin
        add_lhs = {pc, 1'b0};
        add_rhs = '0;
        flow.is_xret   = 1'b0;
        flow.is_jump   = 1'b0;
        flow.is_branch = 1'b0;
        case (rv_isa_pkg::opcode_e'(insn[6:2]))
            rv_isa_pkg::JAL: begin
                flow.is_jump = 1'b1;
                add_rhs = {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};
            end
            rv_isa_pkg::JALR: begin
                flow.is_jump = 1'b1;
                add_lhs = rs1_val;
                add_rhs = {{20{insn[31]}}, insn[31:20]};
            end
            rv_isa_pkg::BRANCH: begin
                flow.is_branch = 1'b1;
                add_rhs = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
            end
            // MRET is the only xRET once S-mode is gone.
            rv_isa_pkg::SYSTEM: flow.is_xret = insn[21] && insn[28];
            default: ;
        endcase
    end

    assign flow.branch_predict = insn[31];
    // Bit 0 of the sum is dropped, which also clears it for JALR.
    assign flow.branch_target  = add_res[rv_isa_pkg::XLEN-1:1];

endmodule

// File: src/boa_stage_id.sv
// Decode stage with one barrier entry held on stall; clear only masks valid and trap.
`timescale 1ns/1ps

module boa_stage_id #(
    parameter bit have_m     = 1'b1,
    parameter bit have_zicsr = 1'b1
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   clear,
    input  logic                   stall,
    input  rv_isa_pkg::priv_e      privilege,
    input  boa_pipe_pkg::if_id_t   d,
    input  boa_pipe_pkg::wb_t      wb,
    output boa_pipe_pkg::id_ex_t   q,
    output boa_pipe_pkg::flow_t    flow
);

    boa_pipe_pkg::if_id_t          r;
    logic [rv_isa_pkg::XLEN-1:0]   rs1_val;
    logic [rv_isa_pkg::XLEN-1:0]   rs2_val;
    logic                          insn_valid;
    logic                          insn_legal;
    logic                          use_rd;

    // Pipeline barrier.
    always_ff @(posedge clk) begin
        if (rst) begin
            r <= '0;
        end else if (!stall) begin
            r <= d;
        end
    end

    boa_regfile u_regfile (
        .clk     (clk),
        .rst     (rst),
        .wb      (wb),
        .rs1     (r.insn[rv_isa_pkg::RS1_LSB +: rv_isa_pkg::REG_IDX_W]),
        .rs2     (r.insn[rv_isa_pkg::RS2_LSB +: rv_isa_pkg::REG_IDX_W]),
        .rs1_val (rs1_val),
        .rs2_val (rs2_val)
    );

    boa_insn_validator #(
        .have_m     (have_m),
        .have_zicsr (have_zicsr)
    ) u_validator (
        .insn      (r.insn),
        .privilege (privilege),
        .valid     (insn_valid),
        .legal     (insn_legal)
    );

    boa_reg_decoder u_reg_decoder (
        .insn   (r.insn),
        .use_rd (use_rd)
    );

    boa_branch_decoder u_branch_decoder (
        .insn    (r.insn),
        .pc      (r.pc),
        .rs1_val (rs1_val),
        .flow    (flow)
    );

    // Output assembly.
    assign q.valid          = r.valid && !clear && insn_valid && insn_legal;
    assign q.pc             = r.pc;
    assign q.insn           = r.insn;
    assign q.use_rd         = use_rd;
    assign q.rs1_val        = rs1_val;
    assign q.rs2_val        = rs2_val;
    assign q.branch         = flow.is_branch;
    assign q.branch_predict = flow.branch_predict;
    // Fetch traps take priority over decode traps.
    assign q.trap  = !clear && (r.trap || (r.valid && (!insn_valid || !insn_legal)));
    assign q.cause = r.trap ? r.cause : rv_isa_pkg::ILLEGAL_INSN;

endmodule

// File: test/boa_stage_id_tb.sv
// Needs have_m and have_zicsr set; outputs are sampled at the falling edge after each capture.
`timescale 1ns/1ps

module boa_stage_id_tb;

    logic                    clk;
    logic                    rst;
    logic                    clear;
    logic                    stall;
    rv_isa_pkg::priv_e       privilege;
    boa_pipe_pkg::if_id_t    d;
    boa_pipe_pkg::wb_t       wb;
    boa_pipe_pkg::id_ex_t    q;
    boa_pipe_pkg::flow_t     flow;
    logic [31:0]             lfsr_state = 32'h4134f8a0;
    logic [31:0]             model [0:31];
    rv_isa_pkg::cause_e      fetch_causes [0:4];
    int                      errors;
    int                      checks;
    int                      cycles;

    boa_stage_id #(.have_m(1'b1), .have_zicsr(1'b1)) u_boa_stage_id (
        .clk(clk), .rst(rst), .clear(clear), .stall(stall), .privilege(privilege),
        .d(d), .wb(wb), .q(q), .flow(flow)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Run limit, about ten times the length of the tests.
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= 3000) begin
            $display("Timeout after %0d cycles, tests did not finish", cycles);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // Fibonacci LFSR, taps 32, 22, 2 and 1.
    function automatic logic lfsr_step();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_step()};
        end
        return v;
    endfunction

    task automatic check_equal(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (exp === act) else begin
            $display("FAIL %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic send_insn(input logic [31:0] insn, input logic [30:0] pc, input logic trap,
                             input rv_isa_pkg::cause_e cause);
        boa_pipe_pkg::if_id_t f;
        f.valid = 1'b1;
        f.pc    = pc;
        f.insn  = insn;
        f.trap  = trap;
        f.cause = cause;
        @(posedge clk);
        d <= f;
        @(posedge clk);
        @(negedge clk);
        check_equal("q.insn", insn, q.insn);
        check_equal("q.pc", 32'(pc), 32'(q.pc));
    endtask

    task automatic write_reg(input logic [4:0] rd, input logic [31:0] val);
        boa_pipe_pkg::wb_t w;
        w.we    = 1'b1;
        w.rd    = rd;
        w.wdata = val;
        @(posedge clk);
        wb <= w;
        @(posedge clk);
        wb <= '0;
        if (rd != 5'd0) begin
            model[rd] = val;
        end
    endtask

    task automatic check_status(input logic valid, input logic trap, input logic [3:0] cause);
        check_equal("q.valid", 32'(valid), 32'(q.valid));
        check_equal("q.trap", 32'(trap), 32'(q.trap));
        if (trap) begin
            check_equal("q.cause", 32'(cause), 32'(q.cause));
        end
    endtask

    task automatic check_flow(input logic jump, input logic branch, input logic predict,
                              input logic [31:0] target);
        check_equal("flow.is_jump", 32'(jump), 32'(flow.is_jump));
        check_equal("flow.is_branch", 32'(branch), 32'(flow.is_branch));
        check_equal("flow.branch_predict", 32'(predict), 32'(flow.branch_predict));
        check_equal("q.branch_predict", 32'(predict), 32'(q.branch_predict));
        check_equal("q.branch", 32'(branch), 32'(q.branch));
        check_equal("flow.branch_target", 32'(target[31:1]), 32'(flow.branch_target));
    endtask

    initial begin
        logic [31:0]        insn;
        logic [31:0]        imm;
        logic [30:0]        pc;
        logic [4:0]         rs1;
        logic [4:0]         rs2;
        logic [2:0]         f3;
        rv_isa_pkg::cause_e fcause;
        rst = 1'b1;
        clear = 1'b0;
        stall = 1'b0;
        privilege = rv_isa_pkg::PRIV_M;
        d = '0;
        wb = '0;
        errors = 0;
        checks = 0;
        cycles = 0;
        fetch_causes[0] = rv_isa_pkg::INSN_MISALIGNED;
        fetch_causes[1] = rv_isa_pkg::INSN_ACCESS_FAULT;
        fetch_causes[2] = rv_isa_pkg::BREAKPOINT;
        fetch_causes[3] = rv_isa_pkg::ECALL_M;
        fetch_causes[4] = rv_isa_pkg::INSN_PAGE_FAULT;
        for (int i = 0; i < 32; i++) begin
            model[i] = '0;
        end
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_status(1'b0, 1'b0, 4'd0);
        check_equal("flow.is_xret", 32'd0, 32'(flow.is_xret));
        check_flow(1'b0, 1'b0, 1'b0, 32'd0);

        // Register file through OP and STORE reads; x0 must ignore writes.
        for (int i = 0; i < 32; i++) begin
            write_reg(5'(i), rand_bits(32));
        end
        for (int i = 0; i < 24; i++) begin
            rs1 = (i == 0) ? 5'd0 : 5'(rand_bits(5));
            rs2 = 5'(rand_bits(5));
            if (i[0]) begin
                insn = {7'b0, rs2, rs1, 3'b000, 5'(rand_bits(5)), 7'b0110011};
            end else begin
                insn = {7'(rand_bits(7)), rs2, rs1, 3'b010, 5'(rand_bits(5)), 7'b0100011};
            end
            send_insn(insn, 31'(rand_bits(31)), 1'b0, rv_isa_pkg::ILLEGAL_INSN);
            check_status(1'b1, 1'b0, 4'd0);
            check_equal("q.rs1_val", model[rs1], q.rs1_val);
            check_equal("q.rs2_val", model[rs2], q.rs2_val);
            check_equal("q.use_rd", 32'(i[0]), 32'(q.use_rd));
        end

        // Illegal encodings.
        send_insn(32'h0000_0012, 31'd0, 1'b0, rv_isa_pkg::INSN_MISALIGNED);
        check_status(1'b0, 1'b1, 4'd2);
        send_insn(32'h0000_2063, 31'd0, 1'b0, rv_isa_pkg::INSN_MISALIGNED);
        check_status(1'b0, 1'b1, 4'd2);
        send_insn(32'h0000_1067, 31'd0, 1'b0, rv_isa_pkg::INSN_MISALIGNED);
        check_status(1'b0, 1'b1, 4'd2);
        send_insn(32'h4000_1013, 31'd0, 1'b0, rv_isa_pkg::INSN_MISALIGNED);
        check_status(1'b0, 1'b1, 4'd2);
        // A fetch trap on a recognised word leaves q.valid set.
        for (int i = 0; i < 6; i++) begin
            fcause = fetch_causes[rand_bits(3) % 32'd5];
            send_insn(32'h0000_0013, 31'd4, 1'b1, fcause);
            check_status(1'b1, 1'b1, fcause);
        end
        send_insn(32'h0220_81b3, 31'd8, 1'b0, rv_isa_pkg::ILLEGAL_INSN);
        check_status(1'b1, 1'b0, 4'd0);

        // Control flow targets, immediates encoded into the word.
        for (int i = 0; i < 60; i++) begin
            pc = 31'(rand_bits(31));
            case (i % 3)
                0: begin
                    imm = rand_bits(21);
                    imm = {{11{imm[20]}}, imm[20:1], 1'b0};
                    insn = {imm[20], imm[10:1], imm[11], imm[19:12], 5'(rand_bits(5)),
                            7'b1101111};
                    send_insn(insn, pc, 1'b0, rv_isa_pkg::ILLEGAL_INSN);
                    check_flow(1'b1, 1'b0, imm[31], {pc, 1'b0} + imm);
                end
                1: begin
                    rs1 = 5'(rand_bits(5));
                    imm = rand_bits(12);
                    imm = {{20{imm[11]}}, imm[11:0]};
                    insn = {imm[11:0], rs1, 3'b000, 5'(rand_bits(5)), 7'b1100111};
                    send_insn(insn, pc, 1'b0, rv_isa_pkg::ILLEGAL_INSN);
                    check_flow(1'b1, 1'b0, imm[31], model[rs1] + imm);
                end
                default: begin
                    f3 = 3'(rand_bits(3));
                    if (f3[2:1] == 2'b01) begin
                        f3[2] = 1'b1;
                    end
                    imm = rand_bits(13);
                    imm = {{19{imm[12]}}, imm[12:1], 1'b0};
                    insn = {imm[12], imm[10:5], 5'(rand_bits(5)), 5'(rand_bits(5)), f3,
                            imm[4:1], imm[11], 7'b1100011};
                    send_insn(insn, pc, 1'b0, rv_isa_pkg::ILLEGAL_INSN);
                    check_flow(1'b0, 1'b1, imm[31], {pc, 1'b0} + imm);
                end
            endcase
            check_status(1'b1, 1'b0, 4'd0);
        end

        // Stall holds q while d changes.
        send_insn(32'h0031_0233, 31'd12, 1'b0, rv_isa_pkg::ILLEGAL_INSN);
        @(posedge clk);
        stall <= 1'b1;
        d.insn <= 32'h0220_81b3;
        d.pc <= 31'd40;
        for (int i = 0; i < 3; i++) begin
            @(negedge clk);
            check_equal("q.insn", 32'h0031_0233, q.insn);
            check_equal("q.pc", 32'd12, 32'(q.pc));
            check_equal("q.rs1_val", model[2], q.rs1_val);
            check_equal("q.rs2_val", model[3], q.rs2_val);
            check_status(1'b1, 1'b0, 4'd0);
        end
        @(posedge clk);
        stall <= 1'b0;

        // Clear masks both a valid item and a decode trap.
        @(posedge clk);
        clear <= 1'b1;
        send_insn(32'h0031_0233, 31'd16, 1'b0, rv_isa_pkg::ILLEGAL_INSN);
        check_status(1'b0, 1'b0, 4'd0);
        send_insn(32'h0000_2063, 31'd20, 1'b0, rv_isa_pkg::ILLEGAL_INSN);
        check_status(1'b0, 1'b0, 4'd0);
        @(posedge clk);
        clear <= 1'b0;

        // MRET only in M mode.
        send_insn(rv_isa_pkg::MRET_WORD, 31'd24, 1'b0, rv_isa_pkg::INSN_MISALIGNED);
        check_status(1'b1, 1'b0, 4'd0);
        check_equal("flow.is_xret", 32'd1, 32'(flow.is_xret));
        @(posedge clk);
        privilege <= rv_isa_pkg::PRIV_U;
        send_insn(rv_isa_pkg::MRET_WORD, 31'd28, 1'b0, rv_isa_pkg::INSN_MISALIGNED);
        check_status(1'b0, 1'b1, 4'd2);
        check_equal("flow.is_xret", 32'd1, 32'(flow.is_xret));

        @(posedge clk);
        $display("Checks: %0d, errors: %0d, cycles: %0d", checks, errors, cycles);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: boa_id.f
src/rv_isa_pkg.sv
src/boa_pipe_pkg.sv
src/boa_regfile.sv
src/boa_insn_validator.sv
src/boa_reg_decoder.sv
src/boa_branch_decoder.sv
src/boa_stage_id.sv
test/boa_stage_id_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds and runs the decode stage testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f boa_id.f --top-module boa_stage_id_tb -o boa_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/boa_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation run returned an error"
    exit 1
fi

if echo "$out" | grep -q "SIMULATION PASSED"; then
    exit 0
fi
exit 1
